// ==== src/rom_loader_defs.svh ====
`ifndef ROM_LOADER_DEFS_SVH
`define ROM_LOADER_DEFS_SVH

// ##############################
// Port widths
// ##############################
`define DL_ADDR_W        25 // Download byte address
`define PROG_ADDR_W      19 // 68010 word address
`define AUDIO_ADDR_W     16
`define CHAR_ADDR_W      14

// Bank depths as log2 of entries
`define PROG_BANK_AW     15 // 9AB 7AB 6AB 5AB 3AB pairs
`define PROG_10AB_AW     14 // Half size pair
`define AUDIO_16S_AW     15
`define AUDIO_16R_AW     14

// ##############################
// Download address map
// ##############################
`define GFX_LIMIT        25'h0C0000 // Graphics below this
`define PROG_9AB_BASE    25'h0C0000
`define PROG_10AB_BASE   25'h0F0000 // D0000..EFFFF is filler
`define PROG_7AB_BASE    25'h100000
`define PROG_6AB_BASE    25'h110000
`define PROG_5AB_BASE    25'h120000
`define PROG_3AB_BASE    25'h130000
`define AUDIO_16S_BASE   25'h140000
`define AUDIO_16R_BASE   25'h148000
`define CHAR_6P_BASE     25'h14C000

// Window sizes in download bytes
`define PROG_PAIR_SIZE   (25'd2 << `PROG_BANK_AW)
`define PROG_10AB_SIZE   (25'd2 << `PROG_10AB_AW)
`define AUDIO_16S_SIZE   (25'd1 << `AUDIO_16S_AW)
`define AUDIO_16R_SIZE   (25'd1 << `AUDIO_16R_AW)
`define CHAR_6P_SIZE     (25'd1 << `CHAR_ADDR_W)

`define RESET_HOLD_CYCLES 16 // Game reset tail after download

`endif

// ==== src/rom_map_pkg.sv ====
package rom_map_pkg;

	// Destination of a download byte
	typedef enum logic [3:0] {
		NONE,      // Filler or past end of map
		GFX,       // Goes to SDRAM only
		PROG_9AB,
		PROG_10AB,
		PROG_7AB,
		PROG_6AB,
		PROG_5AB,
		PROG_3AB,
		AUDIO_16S,
		AUDIO_16R,
		CHAR_6P
	} rom_region_e;

	// One bank write, word for program pairs, byte otherwise
	typedef struct packed {
		logic        valid;  // Single cycle strobe
		rom_region_e region;
		logic [14:0] addr;   // Word or byte address inside bank
		logic [15:0] data;   // Byte ROMs use [7:0]
	} rom_write_t;

	// Dword write toward the SDRAM controller
	typedef struct packed {
		logic        we;
		logic [22:0] addr; // Download address / 4
		logic [31:0] data; // Oldest byte in [31:24]
	} sdram_write_t;

endpackage

// ==== src/load_ctrl_pkg.sv ====
package load_ctrl_pkg;

	// Download index selects what the stream carries
	typedef enum logic [7:0] {
		ROMS      = 8'd0, // Concatenated ROM images
		GAME_TYPE = 8'd1  // Single game type byte
	} dl_index_e;

	// Sequencer phases
	typedef enum logic [1:0] {
		IDLE,
		LOADING,
		HOLD     // Download over, reset still held
	} load_state_e;

	// One byte beat on the download port
	typedef struct packed {
		logic        wr;    // One cycle per byte
		dl_index_e   index;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_beat_t;

endpackage

// ==== src/load_sequencer.sv ====
`timescale 1ns/1ns

module load_sequencer
	import load_ctrl_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst,
	input  logic       download,
	input  dl_beat_t   beat,
	input  logic       hold_done,
	output logic       hold_start,
	output logic       game_reset,
	output logic [7:0] game_type
);

	load_state_e state;
	load_state_e state_next;

	// ##############################
	// Phase tracking
	// ##############################
	always_comb begin
		state_next = state;
		case (state)
			IDLE:    if (download) state_next = LOADING;
			LOADING: if (!download) state_next = HOLD; // Download dropped
			HOLD:    if (hold_done) state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	assign hold_start = (state == LOADING) && !download; // Arms the timer

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			state      <= IDLE;
			game_reset <= 1'b1; // Game stays in reset through rst
		end else begin
			state      <= state_next;
			game_reset <= (state_next != IDLE);
		end
	end

	// Game type byte from its own download index
	always_ff @(posedge clk_sys) begin
		if (rst)
			game_type <= 8'h00;
		else if (beat.wr && beat.index == GAME_TYPE)
			game_type <= beat.data;
	end

	// Timer runs out only while the hold phase waits on it
	a_done_in_hold: assert property (
		@(posedge clk_sys) disable iff (rst)
		hold_done |-> (state == HOLD)
	);

endmodule

// ==== src/reset_hold_timer.sv ====
`timescale 1ns/1ns

`include "rom_loader_defs.svh"

module reset_hold_timer (
	input  logic clk_sys,
	input  logic rst,
	input  logic start,
	output logic done
);

	localparam int CNT_W = $clog2(`RESET_HOLD_CYCLES + 1);

	logic [CNT_W-1:0] count;

	// Load on start then run down to zero
	always_ff @(posedge clk_sys) begin
		if (rst)
			count <= '0;
		else if (start)
			count <= CNT_W'(`RESET_HOLD_CYCLES);
		else if (count != '0)
			count <= count - 1'b1;
	end

	// High in the last counting cycle only
	assign done = (count == CNT_W'(1));

	// Sequencer only re-arms after the previous hold ran out
	a_no_rearm: assert property (
		@(posedge clk_sys) disable iff (rst)
		start |-> (count == '0)
	);

endmodule

// ==== src/rom_write_router.sv ====
`timescale 1ns/1ns

`include "rom_loader_defs.svh"

module rom_write_router
	import rom_map_pkg::*;
	import load_ctrl_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst,
	input  dl_beat_t     beat,
	input  logic         download,
	output rom_write_t   rom_wr,
	output sdram_write_t sdram
);

	logic [`DL_ADDR_W-1:0] addr;
	logic                  rom_beat;   // ROM byte accepted this cycle
	logic [23:0]           acc;        // Last three ROM bytes, newest low
	rom_region_e           region;
	logic                  is_pair;    // 16-bit program interleave
	logic                  take_byte;  // Bank write due
	logic [14:0]           wr_addr;

	function automatic logic in_window(
		input logic [`DL_ADDR_W-1:0] a,
		input logic [`DL_ADDR_W-1:0] base,
		input logic [`DL_ADDR_W-1:0] size
	);
		return (a >= base) && (a < base + size);
	endfunction

	// ##############################
	// Download map decode
	// ##############################
	function automatic rom_region_e decode_region(input logic [`DL_ADDR_W-1:0] a);
		rom_region_e r;
		if (a < `GFX_LIMIT)                                        r = GFX;
		else if (in_window(a, `PROG_9AB_BASE,  `PROG_PAIR_SIZE))  r = PROG_9AB;
		else if (in_window(a, `PROG_10AB_BASE, `PROG_10AB_SIZE))  r = PROG_10AB;
		else if (in_window(a, `PROG_7AB_BASE,  `PROG_PAIR_SIZE))  r = PROG_7AB;
		else if (in_window(a, `PROG_6AB_BASE,  `PROG_PAIR_SIZE))  r = PROG_6AB;
		else if (in_window(a, `PROG_5AB_BASE,  `PROG_PAIR_SIZE))  r = PROG_5AB;
		else if (in_window(a, `PROG_3AB_BASE,  `PROG_PAIR_SIZE))  r = PROG_3AB;
		else if (in_window(a, `AUDIO_16S_BASE, `AUDIO_16S_SIZE))  r = AUDIO_16S;
		else if (in_window(a, `AUDIO_16R_BASE, `AUDIO_16R_SIZE))  r = AUDIO_16R;
		else if (in_window(a, `CHAR_6P_BASE,   `CHAR_6P_SIZE))    r = CHAR_6P;
		else                                                       r = NONE; // Filler
		return r;
	endfunction

	assign addr     = beat.addr;
	assign rom_beat = beat.wr && (beat.index == ROMS) && download;
	assign region   = decode_region(addr);
	assign is_pair  = region inside {PROG_9AB, PROG_10AB, PROG_7AB,
		PROG_6AB, PROG_5AB, PROG_3AB};

	// Pairs complete on the odd byte
	assign take_byte = rom_beat && (region != NONE) && (region != GFX)
		&& (!is_pair || addr[0]);

	// Address inside the target bank
	always_comb begin
		case (region)
			PROG_10AB: wr_addr = 15'(addr[`PROG_10AB_AW:1]);
			PROG_9AB, PROG_7AB, PROG_6AB, PROG_5AB, PROG_3AB:
				wr_addr = addr[`PROG_BANK_AW:1];
			AUDIO_16S: wr_addr = addr[`AUDIO_16S_AW-1:0];
			default:   wr_addr = 15'(addr[`AUDIO_16R_AW-1:0]); // 16R and 6P
		endcase
	end

	// ##############################
	// Registered strobes
	// ##############################
	always_ff @(posedge clk_sys) begin
		if (rom_beat)
			acc <= {acc[15:0], beat.data}; // Shift in newest byte
		if (take_byte) begin
			rom_wr.region <= region;
			rom_wr.addr   <= wr_addr;
			rom_wr.data   <= is_pair ? {acc[7:0], beat.data} : {8'h00, beat.data};
		end
		if (rom_beat && addr[1:0] == 2'b11) begin
			sdram.addr <= addr[`DL_ADDR_W-1:2]; // Dword address
			sdram.data <= {acc, beat.data};
		end
		if (rst) begin
			rom_wr.valid <= 1'b0;
			sdram.we     <= 1'b0;
		end else begin
			rom_wr.valid <= take_byte;
			sdram.we     <= rom_beat && (addr[1:0] == 2'b11);
		end
	end

	// ROM bytes outside a download would be lost
	a_rom_beat_in_download: assert property (
		@(posedge clk_sys) disable iff (rst)
		(beat.wr && beat.index == ROMS) |-> download
	);

endmodule

// ==== src/rom_banks.sv ====
`timescale 1ns/1ns

`include "rom_loader_defs.svh"

module rom_banks
	import rom_map_pkg::*;
(
	input  logic                     clk_sys,
	input  rom_write_t               rom_wr,
	input  logic [`PROG_ADDR_W-1:0]  prog_addr,
	output logic [15:0]              prog_data,
	input  logic [`AUDIO_ADDR_W-1:0] audio_addr,
	output logic [7:0]               audio_data,
	input  logic [`CHAR_ADDR_W-1:0]  char_addr,
	output logic [7:0]               char_data
);

	localparam int NPAIR = 5;
	// Full size pairs in generate order
	localparam rom_region_e PAIR_REGION [NPAIR] =
		'{PROG_9AB, PROG_7AB, PROG_6AB, PROG_5AB, PROG_3AB};

	logic [15:0] pair_q [NPAIR];
	logic [15:0] prog_10ab_q;
	logic [4:0]  prog_sel_q;  // prog_addr[18:14] of the read
	logic [7:0]  audio_16s_q;
	logic [7:0]  audio_16r_q;
	logic        audio_sel_q;

	logic [15:0] prog_10ab_mem [2**`PROG_10AB_AW];
	logic [7:0]  audio_16s_mem [2**`AUDIO_16S_AW];
	logic [7:0]  audio_16r_mem [2**`AUDIO_16R_AW];
	logic [7:0]  char_6p_mem   [2**`CHAR_ADDR_W];

	// ##############################
	// 68010 program pairs
	// ##############################
	for (genvar b = 0; b < NPAIR; b++) begin : g_pair
		logic [15:0] mem [2**`PROG_BANK_AW];
		always_ff @(posedge clk_sys) begin
			if (rom_wr.valid && rom_wr.region == PAIR_REGION[b])
				mem[rom_wr.addr] <= rom_wr.data;
			pair_q[b] <= mem[prog_addr[`PROG_BANK_AW-1:0]];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rom_wr.valid && rom_wr.region == PROG_10AB)
			prog_10ab_mem[rom_wr.addr[`PROG_10AB_AW-1:0]] <= rom_wr.data;
		prog_10ab_q <= prog_10ab_mem[prog_addr[`PROG_10AB_AW-1:0]];
		prog_sel_q  <= prog_addr[`PROG_ADDR_W-1:`PROG_ADDR_W-5];
	end

	// Bank select on the registered upper bits
	always_comb begin
		casez (prog_sel_q)
			5'b0000?: prog_data = pair_q[0]; // 9AB
			5'b00110: prog_data = prog_10ab_q;
			5'b0100?: prog_data = pair_q[1]; // 7AB
			5'b0101?: prog_data = pair_q[2]; // 6AB
			5'b0110?: prog_data = pair_q[3]; // 5AB
			5'b0111?: prog_data = pair_q[4]; // 3AB
			default:  prog_data = 16'h0000;  // Unmapped
		endcase
	end

	// ##############################
	// Audio and character bytes
	// ##############################
	always_ff @(posedge clk_sys) begin
		if (rom_wr.valid && rom_wr.region == AUDIO_16S)
			audio_16s_mem[rom_wr.addr[`AUDIO_16S_AW-1:0]] <= rom_wr.data[7:0];
		if (rom_wr.valid && rom_wr.region == AUDIO_16R)
			audio_16r_mem[rom_wr.addr[`AUDIO_16R_AW-1:0]] <= rom_wr.data[7:0];
		audio_16s_q <= audio_16s_mem[audio_addr[`AUDIO_16S_AW-1:0]];
		audio_16r_q <= audio_16r_mem[audio_addr[`AUDIO_16R_AW-1:0]];
		audio_sel_q <= audio_addr[`AUDIO_ADDR_W-1]; // Upper half is 16S
	end

	assign audio_data = audio_sel_q ? audio_16s_q : audio_16r_q;

	always_ff @(posedge clk_sys) begin
		if (rom_wr.valid && rom_wr.region == CHAR_6P)
			char_6p_mem[rom_wr.addr[`CHAR_ADDR_W-1:0]] <= rom_wr.data[7:0];
		char_data <= char_6p_mem[char_addr];
	end

endmodule

// ==== src/rom_loader_top.sv ====
`timescale 1ns/1ns

`include "rom_loader_defs.svh"

module rom_loader_top
	import rom_map_pkg::*;
	import load_ctrl_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     rst,
	input  logic                     download,
	input  dl_beat_t                 beat,
	output sdram_write_t             sdram,
	output logic                     game_reset,
	output logic [7:0]               game_type,
	input  logic [`PROG_ADDR_W-1:0]  prog_addr,
	output logic [15:0]              prog_data,
	input  logic [`AUDIO_ADDR_W-1:0] audio_addr,
	output logic [7:0]               audio_data,
	input  logic [`CHAR_ADDR_W-1:0]  char_addr,
	output logic [7:0]               char_data
);

	rom_write_t rom_wr;     // Router to banks
	logic       hold_start;
	logic       hold_done;

	// Download phases and game reset
	load_sequencer u_seq (
		.clk_sys, .rst, .download, .beat, .hold_done,
		.hold_start, .game_reset, .game_type
	);

	reset_hold_timer u_hold (
		.clk_sys, .rst, .start(hold_start), .done(hold_done)
	);

	// Byte stream to bank and SDRAM strobes
	rom_write_router u_router (
		.clk_sys, .rst, .beat, .download, .rom_wr, .sdram
	);

	rom_banks u_banks (
		.clk_sys, .rom_wr,
		.prog_addr, .prog_data,
		.audio_addr, .audio_data,
		.char_addr, .char_data
	);

endmodule

// ==== verification/tb_rom_loader.sv ====
`timescale 1ns/1ns

`include "rom_loader_defs.svh"

module tb_rom_loader
	import rom_map_pkg::*;
	import load_ctrl_pkg::*;
();

	logic                     clk_sys;
	logic                     rst;
	logic                     download;
	dl_beat_t                 beat;
	sdram_write_t             sdram;
	logic                     game_reset;
	logic [7:0]               game_type;
	logic [`PROG_ADDR_W-1:0]  prog_addr;
	logic [15:0]              prog_data;
	logic [`AUDIO_ADDR_W-1:0] audio_addr;
	logic [7:0]               audio_data;
	logic [`CHAR_ADDR_W-1:0]  char_addr;
	logic [7:0]               char_data;

	// Program pairs in download order
	localparam int PAIR_DL [6] = '{`PROG_9AB_BASE, `PROG_10AB_BASE, `PROG_7AB_BASE,
		`PROG_6AB_BASE, `PROG_5AB_BASE, `PROG_3AB_BASE};
	localparam int PAIR_SIZE [6] = '{'h10000, 'h8000, 'h10000, 'h10000, 'h10000, 'h10000};
	localparam int PAIR_WORD [6] = '{'h00000, 'h18000, 'h20000, 'h28000, 'h30000, 'h38000};

	logic [31:0]  stim [256];          // Four words per operation
	logic [31:0]  rng = 32'h0afa35ed;
	logic [23:0]  hist = '0;           // Last three ROM bytes, newest low
	logic [7:0]   type_exp = 8'h00;
	logic [15:0]  model [int];         // Key is port << 20 | read address
	sdram_write_t sd_exp [$];
	int           sd_due [$];          // Monitor cycle of each strobe
	int           ncyc;
	int           cycles;
	int           limit;
	int           mismatches;
	int           failures;
	int           rom_writes;
	bit           dl_prev;
	bit           sd_hit;

	rom_loader_top uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys; // 40 ns period
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] got,
		input logic [63:0] exp);
		mismatches++;
		$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
	endtask

	// ##############################
	// Address map model
	// ##############################
	task automatic model_rom_byte(input int a, input logic [7:0] d);
		sdram_write_t e;
		for (int p = 0; p < 6; p++) begin
			if (a >= PAIR_DL[p] && a < PAIR_DL[p] + PAIR_SIZE[p] && a[0])
				model[PAIR_WORD[p] + (a - PAIR_DL[p]) / 2] = {hist[7:0], d}; // Even byte high
		end
		if (a >= `AUDIO_16S_BASE && a < `AUDIO_16S_BASE + 'h8000)
			model[(1 << 20) | 'h8000 | (a - `AUDIO_16S_BASE)] = {8'h00, d}; // Upper half
		if (a >= `AUDIO_16R_BASE && a < `AUDIO_16R_BASE + 'h4000)
			model[(1 << 20) | (a - `AUDIO_16R_BASE)] = {8'h00, d};
		if (a >= `CHAR_6P_BASE && a < `CHAR_6P_BASE + 'h4000)
			model[(2 << 20) | (a - `CHAR_6P_BASE)] = {8'h00, d};
		if (a % 4 == 3) begin // Dword complete
			e.we   = 1'b1;
			e.addr = 23'(a / 4);
			e.data = {hist, d};
			sd_exp.push_back(e);
			sd_due.push_back(ncyc + 2);
		end
		hist = {hist[15:0], d};
	endtask

	// ##############################
	// Operations
	// ##############################
	task automatic start_download();
		@(posedge clk_sys);
		download <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		assert (game_reset) else begin
			failures++;
			$display("game_reset did not rise after download started");
		end
	endtask

	task automatic end_download(input int tail_exp);
		int tail = 0;
		@(posedge clk_sys);
		download <= 1'b0;
		@(negedge clk_sys);
		while (game_reset && tail < 64) begin // Cycles still in reset
			tail++;
			@(negedge clk_sys);
		end
		assert (tail == tail_exp) else report_mismatch("game_reset tail", tail, tail_exp);
	endtask

	task automatic drive_beats(input int base, input int count, input int idx);
		int writes_before = rom_writes;
		int a;
		for (int i = 0; i < count; i++) begin
			@(posedge clk_sys);
			rng = xorshift(rng);
			// Game type beats sit on char ROM dword ends, so any leak would write
			a = (idx == GAME_TYPE) ? `CHAR_6P_BASE + 3 + 4 * i : base + i;
			beat.wr    <= 1'b1;
			beat.index <= dl_index_e'(idx);
			beat.addr  <= 25'(a);
			beat.data  <= rng[7:0];
			if (idx == GAME_TYPE)
				type_exp = rng[7:0];
			else
				model_rom_byte(a, rng[7:0]);
		end
		@(posedge clk_sys);
		beat.wr <= 1'b0;
		@(negedge clk_sys);
		assert (game_type == type_exp) else report_mismatch("game_type", game_type, type_exp);
		@(posedge clk_sys); // Last bank write counted by now
		if (idx == GAME_TYPE) begin
			assert (rom_writes == writes_before) else begin
				failures++;
				$display("Game type beat caused a ROM bank write");
			end
		end
	endtask

	task automatic check_read(input int port, input int a, input bit loaded);
		int          key = (port << 20) | a;
		logic [15:0] got;
		logic [15:0] exp = 16'h0000; // Unmapped program space
		@(posedge clk_sys);
		case (port)
			0:       prog_addr <= a[`PROG_ADDR_W-1:0];
			1:       audio_addr <= a[`AUDIO_ADDR_W-1:0];
			default: char_addr <= a[`CHAR_ADDR_W-1:0];
		endcase
		@(posedge clk_sys);
		@(negedge clk_sys); // Registered read
		case (port)
			0:       got = prog_data;
			1:       got = {8'h00, audio_data};
			default: got = {8'h00, char_data};
		endcase
		if (loaded) begin
			assert (model.exists(key)) else begin
				failures++;
				$display("Read of port %0d address %0h that no download wrote", port, a);
			end
			if (model.exists(key))
				exp = model[key];
		end
		assert (got === exp) else report_mismatch($sformatf("port %0d @%0h", port, a), got, exp);
	endtask

	// ##############################
	// Per cycle monitor
	// ##############################
	always @(negedge clk_sys) begin
		ncyc++;
		if (uut.rom_wr.valid)
			rom_writes++;
		if (!rst && dl_prev && download) begin
			assert (game_reset) else begin
				failures++;
				$display("game_reset low during a download at %0t ns", $time);
			end
		end
		dl_prev = download;
		sd_hit = (sd_due.size() != 0) && (sd_due[0] == ncyc);
		if (sdram.we) begin
			assert (sd_hit) else begin
				failures++;
				$display("Unexpected SDRAM strobe at %0t ns", $time);
			end
			if (sd_hit) begin
				assert (sdram == sd_exp[0]) else report_mismatch("sdram", sdram, sd_exp[0]);
				void'(sd_exp.pop_front());
				void'(sd_due.pop_front());
			end
		end else if (sd_due.size() != 0 && sd_due[0] <= ncyc) begin
			failures++;
			$display("Missing SDRAM strobe at %0t ns", $time);
			void'(sd_exp.pop_front());
			void'(sd_due.pop_front());
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > limit) begin
			$display("Timeout: run passed %0d cycles", limit);
			$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		int pc;
		rst        = 1'b1;
		download   = 1'b0;
		beat       = '0;
		prog_addr  = '0;
		audio_addr = '0;
		char_addr  = '0;
		$readmemh("verification/rom_stim.txt", stim);
		limit = 0;
		for (pc = 0; pc < 252 && stim[pc] != 0; pc += 4)
			limit += (stim[pc] == 3) ? stim[pc+2] + 4 : (stim[pc] == 2) ? stim[pc+1] + 8 : 4;
		limit = 2 * limit + 64; // Margin plus reset
		repeat (15) @(posedge clk_sys);
		@(negedge clk_sys);
		assert (game_reset && !sdram.we && !uut.rom_wr.valid && game_type == 8'h00) else begin
			failures++;
			$display("Outputs not in their reset state during rst");
		end
		@(posedge clk_sys);
		rst <= 1'b0; // 16 cycles of reset
		for (pc = 0; pc < 252 && stim[pc] != 0; pc += 4) begin
			case (stim[pc])
				1:       start_download();
				2:       end_download(stim[pc+1]);
				3:       drive_beats(stim[pc+1], stim[pc+2], stim[pc+3]);
				4:       check_read(stim[pc+1], stim[pc+2], stim[pc+3][0]);
				default: begin
					failures++;
					$display("Unknown stimulus operation %0h", stim[pc]);
				end
			endcase
		end
		repeat (4) @(posedge clk_sys);
		assert (sd_due.size() == 0) else begin
			failures++;
			$display("%0d SDRAM strobes never appeared", sd_due.size());
		end
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches + failures == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== verification/rom_stim.txt ====
// op a b c: 1 download start, 2 download end (a reset tail cycles), 0 end of stimulus
// 3 beats (a base, b count, c index), 4 read (a port 0 prog 1 audio 2 char, b addr, c loaded)
1 0 0 0
3 0 10 0
3 c0000 8 0
3 f0000 8 0
3 100010 8 0
3 110000 4 0
3 12fff8 8 0
3 130100 4 0
3 d0000 4 0
3 140000 4 0
3 147ffc 4 0
3 148000 4 0
3 14c000 8 0
2 11 0 0
1 0 0 0
3 0 1 1
2 11 0 0
4 0 3 1
4 0 18002 1
4 0 2000b 1
4 0 28001 1
4 0 37fff 1
4 0 38080 1
4 0 8000 0
4 0 1c000 0
4 0 40000 0
4 1 8000 1
4 1 ffff 1
4 1 2 1
4 2 5 1
0 0 0 0

// ==== verilog.f ====
+incdir+src
src/rom_map_pkg.sv
src/load_ctrl_pkg.sv
src/load_sequencer.sv
src/reset_hold_timer.sv
src/rom_write_router.sv
src/rom_banks.sv
src/rom_loader_top.sv
verification/tb_rom_loader.sv

// ==== Bender.yml ====
package:
  name: rom_loader

sources:
  - include_dirs:
      - src
    files:
      - src/rom_map_pkg.sv
      - src/load_ctrl_pkg.sv
      - src/load_sequencer.sv
      - src/reset_hold_timer.sv
      - src/rom_write_router.sv
      - src/rom_banks.sv
      - src/rom_loader_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_rom_loader.sv
